//--- hdl/alu_core.sv
`timescale 1ns/1ps

`include "lab_defs.svh"

module alu_core (
    input  logic              clk,
    input  logic              rst_n,
    input  lab_pkg::alu_req_t req,
    output lab_pkg::alu_res_t res
);

    localparam int W = `LAB_DATA_W;

    logic [W:0]   sum_w;    // extra bit is carry out
    logic [W:0]   diff_w;   // extra bit is borrow
    logic [W-1:0] y;
    logic         carry;
    logic         ovf;

    assign sum_w  = {1'b0, req.a} + {1'b0, req.b} + {{W{1'b0}}, req.cin};
    assign diff_w = {1'b0, req.a} - {1'b0, req.b} - {{W{1'b0}}, req.cin};

    always_comb begin
        y     = '0;
        carry = 1'b0;
        ovf   = 1'b0;
        unique case (req.op)
            lab_pkg::op_add: begin
                y     = sum_w[W-1:0];
                carry = sum_w[W];
                ovf   = (req.a[W-1] == req.b[W-1]) && (sum_w[W-1] != req.a[W-1]);
            end
            lab_pkg::op_sub: begin
                y     = diff_w[W-1:0];
                carry = diff_w[W];
                ovf   = (req.a[W-1] != req.b[W-1]) && (diff_w[W-1] != req.a[W-1]);
            end
            lab_pkg::op_and:   y = req.a & req.b;
            lab_pkg::op_or:    y = req.a | req.b;
            lab_pkg::op_xor:   y = req.a ^ req.b;
            lab_pkg::op_not_a: y = ~req.a;
            lab_pkg::op_lt:    y = W'(req.a < req.b);
            lab_pkg::op_eq:    y = W'(req.a == req.b);
            default: begin
                y = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res <= '0;
        end else begin
            res.s     <= y;
            res.carry <= carry;
            res.ovf   <= ovf;
            res.zero  <= (y == '0);
            res.a     <= req.a;     // operands ride along for display
            res.b     <= req.b;
        end
    end

endmodule

//--- hdl/input_decode.sv
`timescale 1ns/1ps

`include "lab_defs.svh"

module input_decode (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [7:0]             a,
    input  logic [1:0]             s,
    input  logic [2:0]             x,
    input  logic                   en,
    input  logic [7:0]             ec_x,
    input  logic                   ec_en,
    input  logic [`LAB_DATA_W-1:0] alu_a,
    input  logic [`LAB_DATA_W-1:0] alu_b,
    input  logic                   alu_c,
    input  lab_pkg::alu_op_e       alu_op,
    output lab_pkg::decode_out_t   dec,
    output lab_pkg::alu_req_t      req
);

    lab_pkg::decode_out_t dec_d;
    lab_pkg::alu_req_t    req_d;

    always_comb begin
        dec_d = '0;

        dec_d.mux_y = a[{s, 1'b0} +: 2];   // pair s of a

        if (en) begin
            dec_d.dec_y = 8'b1 << x;
        end

        // highest set bit wins
        if (ec_en && (ec_x != 8'h00)) begin
            dec_d.enc_valid = 1'b1;
            for (int i = 0; i < 8; i++) begin
                if (ec_x[i]) begin
                    dec_d.enc_y = 3'(i);
                end
            end
        end
    end

    always_comb begin
        req_d.a   = alu_a;
        req_d.b   = alu_b;
        req_d.cin = alu_c;
        req_d.op  = alu_op;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec <= '0;
            req <= '0;
        end else begin
            dec <= dec_d;
            req <= req_d;   // same cycle as decode
        end
    end

endmodule

//--- hdl/lab_defs.svh
`ifndef LAB_DEFS_SVH
`define LAB_DEFS_SVH

// alu operand width
`define LAB_DATA_W 4

// board widths
`define LAB_SW_W 8
`define LAB_LED_W 16
`define LAB_SEG_W 8

// clock cycles per led step
`define LAB_LED_STEP 4

// active low with all segments and dp off
`define LAB_SEG_BLANK 8'hFF

`endif

//--- hdl/lab_pkg.sv
`include "lab_defs.svh"

package lab_pkg;

    typedef enum logic [2:0] {
        op_add   = 3'd0,
        op_sub   = 3'd1,
        op_and   = 3'd2,
        op_or    = 3'd3,
        op_xor   = 3'd4,
        op_not_a = 3'd5,
        op_lt    = 3'd6,   // unsigned compare
        op_eq    = 3'd7
    } alu_op_e;

    typedef enum logic {
        led_hold = 1'b0,
        led_run  = 1'b1
    } led_state_e;

    typedef struct packed {
        logic [`LAB_DATA_W-1:0] a;
        logic [`LAB_DATA_W-1:0] b;
        logic                   cin;
        alu_op_e                op;
    } alu_req_t;

    typedef struct packed {
        logic [1:0] mux_y;
        logic [7:0] dec_y;
        logic [2:0] enc_y;
        logic       enc_valid;
    } decode_out_t;

    typedef struct packed {
        logic [`LAB_DATA_W-1:0] s;
        logic                   carry;  // borrow for op_sub
        logic                   ovf;
        logic                   zero;
        logic [`LAB_DATA_W-1:0] a;
        logic [`LAB_DATA_W-1:0] b;
    } alu_res_t;

endpackage

//--- hdl/lab_top.sv
`timescale 1ns/1ps

`include "lab_defs.svh"

module lab_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`LAB_SW_W-1:0]   sw,
    input  logic [7:0]             a,
    input  logic [1:0]             s,
    input  logic [2:0]             x,
    input  logic                   en,
    input  logic [7:0]             ec_x,
    input  logic                   ec_en,
    input  logic [`LAB_DATA_W-1:0] alu_a,
    input  logic [`LAB_DATA_W-1:0] alu_b,
    input  logic                   alu_c,
    input  lab_pkg::alu_op_e       alu_op,
    output logic [`LAB_LED_W-1:0]  ledr,
    output logic [1:0]             y,
    output logic [7:0]             y_dec,
    output logic [2:0]             ec_y,
    output logic                   ec_valid,
    output logic [`LAB_DATA_W-1:0] alu_s,
    output logic                   alu_c_out,
    output logic                   alu_ovf,
    output logic                   alu_zero,
    output logic [`LAB_SEG_W-1:0]  seg0,
    output logic [`LAB_SEG_W-1:0]  seg1,
    output logic [`LAB_SEG_W-1:0]  seg2,
    output logic [`LAB_SEG_W-1:0]  seg3,
    output logic [`LAB_SEG_W-1:0]  seg4,
    output logic [`LAB_SEG_W-1:0]  seg5,
    output logic [`LAB_SEG_W-1:0]  seg6,
    output logic [`LAB_SEG_W-1:0]  seg7
);

    lab_pkg::decode_out_t dec;
    lab_pkg::alu_req_t    req;
    lab_pkg::alu_res_t    res;

    input_decode u_decode (
        .clk(clk), .rst_n(rst_n),
        .a(a), .s(s), .x(x), .en(en),
        .ec_x(ec_x), .ec_en(ec_en),
        .alu_a(alu_a), .alu_b(alu_b), .alu_c(alu_c), .alu_op(alu_op),
        .dec(dec), .req(req)
    );

    alu_core u_alu (.clk(clk), .rst_n(rst_n), .req(req), .res(res));

    seg_result u_seg (
        .clk(clk), .rst_n(rst_n), .res(res), .dec(dec), .sw(sw),
        .seg0(seg0), .seg1(seg1), .seg2(seg2), .seg3(seg3),
        .seg4(seg4), .seg5(seg5), .seg6(seg6), .seg7(seg7)
    );

    led_flow u_led (.clk(clk), .rst_n(rst_n), .sw(sw), .ledr(ledr));

    assign y         = dec.mux_y;     // stage 1 outputs
    assign y_dec     = dec.dec_y;
    assign ec_y      = dec.enc_y;
    assign ec_valid  = dec.enc_valid;
    assign alu_s     = res.s;         // stage 2 outputs
    assign alu_c_out = res.carry;
    assign alu_ovf   = res.ovf;
    assign alu_zero  = res.zero;

endmodule

//--- hdl/led_flow.sv
`timescale 1ns/1ps

`include "lab_defs.svh"

module led_flow (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`LAB_SW_W-1:0]  sw,
    output logic [`LAB_LED_W-1:0] ledr
);

    localparam int CNT_W = (`LAB_LED_STEP > 1) ? $clog2(`LAB_LED_STEP) : 1;

    lab_pkg::led_state_e state;
    logic [CNT_W-1:0]    step_cnt;
    logic                step_hit;

    assign step_hit = (step_cnt == CNT_W'(`LAB_LED_STEP - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= lab_pkg::led_hold;
        end else begin
            case (state)
                lab_pkg::led_hold: if (sw[0]) state <= lab_pkg::led_run;
                lab_pkg::led_run:  if (!sw[0]) state <= lab_pkg::led_hold;
                default:           state <= lab_pkg::led_hold;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_cnt <= '0;
            ledr     <= `LAB_LED_W'(1);
        end else if (state == lab_pkg::led_run && sw[0]) begin
            if (step_hit) begin
                step_cnt <= '0;
                if (sw[1]) begin
                    ledr <= {ledr[0], ledr[`LAB_LED_W-1:1]};   // rotate right
                end else begin
                    ledr <= {ledr[`LAB_LED_W-2:0], ledr[`LAB_LED_W-1]};
                end
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end
        end else begin
            step_cnt <= '0;   // pattern holds in place
        end
    end

endmodule

//--- hdl/seg_result.sv
`timescale 1ns/1ps

`include "lab_defs.svh"

module seg_result (
    input  logic                    clk,
    input  logic                    rst_n,
    input  lab_pkg::alu_res_t       res,
    input  lab_pkg::decode_out_t    dec,
    input  logic [`LAB_SW_W-1:0]    sw,
    output logic [`LAB_SEG_W-1:0]   seg0,
    output logic [`LAB_SEG_W-1:0]   seg1,
    output logic [`LAB_SEG_W-1:0]   seg2,
    output logic [`LAB_SEG_W-1:0]   seg3,
    output logic [`LAB_SEG_W-1:0]   seg4,
    output logic [`LAB_SEG_W-1:0]   seg5,
    output logic [`LAB_SEG_W-1:0]   seg6,
    output logic [`LAB_SEG_W-1:0]   seg7
);

    // active low codes with dp in bit 7 kept off
    function automatic logic [`LAB_SEG_W-1:0] hex_to_seg(input logic [3:0] v);
        logic [`LAB_SEG_W-1:0] code;
        case (v)
            4'h0: code = 8'hC0;
            4'h1: code = 8'hF9;
            4'h2: code = 8'hA4;
            4'h3: code = 8'hB0;
            4'h4: code = 8'h99;
            4'h5: code = 8'h92;
            4'h6: code = 8'h82;
            4'h7: code = 8'hF8;
            4'h8: code = 8'h80;
            4'h9: code = 8'h90;
            4'hA: code = 8'h88;
            4'hB: code = 8'h83;   // lower case b
            4'hC: code = 8'hC6;
            4'hD: code = 8'hA1;   // lower case d
            4'hE: code = 8'h86;
            default: code = 8'h8E;
        endcase
        return code;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seg0 <= `LAB_SEG_BLANK;
            seg1 <= `LAB_SEG_BLANK;
            seg2 <= `LAB_SEG_BLANK;
            seg3 <= `LAB_SEG_BLANK;
            seg4 <= `LAB_SEG_BLANK;
            seg5 <= `LAB_SEG_BLANK;
            seg6 <= `LAB_SEG_BLANK;
            seg7 <= `LAB_SEG_BLANK;
        end else begin
            seg0 <= hex_to_seg(res.s);
            seg1 <= hex_to_seg({1'b0, res.zero, res.ovf, res.carry});
            seg2 <= hex_to_seg(res.a);
            seg3 <= hex_to_seg(res.b);
            seg4 <= dec.enc_valid ? hex_to_seg({1'b0, dec.enc_y}) : `LAB_SEG_BLANK;
            seg5 <= hex_to_seg({2'b00, dec.mux_y});
            seg6 <= hex_to_seg(sw[3:0]);
            seg7 <= hex_to_seg(sw[7:4]);
        end
    end

endmodule

//--- project.f
+incdir+hdl
hdl/lab_pkg.sv
hdl/input_decode.sv
hdl/alu_core.sv
hdl/seg_result.sv
hdl/led_flow.sv
hdl/lab_top.sv
tests/tb_clock.sv
tests/tb_lab_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f project.f --top-module tb_lab_top -o sim_tb --Mdir obj_dir

# the simulator may exit nonzero on failure, the log decides
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD = 10.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2.0) clk = ~clk;

endmodule

//--- tests/tb_lab_top.sv
`timescale 1ns/1ps

`include "lab_defs.svh"

module tb_lab_top;

    typedef struct packed {
        logic [7:0]       a;
        logic [1:0]       s;
        logic [2:0]       x;
        logic             en;
        logic [7:0]       ec_x;
        logic             ec_en;
        lab_pkg::alu_op_e op;
        logic [3:0]       aa;
        logic [3:0]       bb;
        logic             cin;
        logic [7:0]       sw;
        logic [3:0]       es;
        logic [2:0]       cvz;    // carry, overflow, zero
    } row_t;

    localparam int N_RAND = 40;
    localparam int WATCH_CYC = 16 + 30 + N_RAND + 20 * `LAB_LED_STEP + 200;

    logic clk, rst_n, en, ec_en, alu_c;
    logic [7:0] sw, a, ec_x;
    logic [1:0] s;
    logic [2:0] x;
    logic [3:0] alu_a, alu_b;
    lab_pkg::alu_op_e alu_op;
    logic [15:0] ledr;
    logic [1:0] y;
    logic [7:0] y_dec;
    logic [2:0] ec_y;
    logic ec_valid, alu_c_out, alu_ovf, alu_zero;
    logic [3:0] alu_s;
    logic [7:0] seg0, seg1, seg2, seg3, seg4, seg5, seg6, seg7;

    row_t rows[$];
    logic [31:0] lfsr = 32'h6975;
    logic [7:0] seg_tab [0:15] = '{8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
                                   8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E};

    tb_clock u_clk (.clk(clk));

    lab_top u_dut (
        .clk(clk), .rst_n(rst_n), .sw(sw), .a(a), .s(s), .x(x), .en(en),
        .ec_x(ec_x), .ec_en(ec_en), .alu_a(alu_a), .alu_b(alu_b), .alu_c(alu_c),
        .alu_op(alu_op), .ledr(ledr), .y(y), .y_dec(y_dec), .ec_y(ec_y),
        .ec_valid(ec_valid), .alu_s(alu_s), .alu_c_out(alu_c_out), .alu_ovf(alu_ovf),
        .alu_zero(alu_zero), .seg0(seg0), .seg1(seg1), .seg2(seg2), .seg3(seg3),
        .seg4(seg4), .seg5(seg5), .seg6(seg6), .seg7(seg7)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v[i] = lfsr[0];
        end
        return v;
    endfunction

    function automatic logic [7:0] seg_of(input logic [3:0] v);
        return seg_tab[v];
    endfunction

    function automatic logic [6:0] ref_alu(input logic [3:0] aa, input logic [3:0] bb,
                                           input logic cin, input lab_pkg::alu_op_e op);
        int ua, ub, sa, sb, t, st;
        logic [3:0] r;
        logic c, v;
        ua = int'(aa);
        ub = int'(bb);
        sa = (ua > 7) ? ua - 16 : ua;
        sb = (ub > 7) ? ub - 16 : ub;
        c = 1'b0;
        v = 1'b0;
        r = 4'h0;
        case (op)
            lab_pkg::op_add: begin
                t = ua + ub + int'(cin);
                st = sa + sb + int'(cin);
                r = 4'(t);
                c = (t > 15);
                v = (st > 7) || (st < -8);
            end
            lab_pkg::op_sub: begin
                t = ua - ub - int'(cin);
                st = sa - sb - int'(cin);
                r = 4'(t);
                c = (t < 0);   // borrow
                v = (st > 7) || (st < -8);
            end
            lab_pkg::op_and:   r = aa & bb;
            lab_pkg::op_or:    r = aa | bb;
            lab_pkg::op_xor:   r = aa ^ bb;
            lab_pkg::op_not_a: r = ~aa;
            lab_pkg::op_lt:    r = (ua < ub) ? 4'd1 : 4'd0;
            default:           r = (ua == ub) ? 4'd1 : 4'd0;
        endcase
        return {r, c, v, (r == 4'd0)};
    endfunction

    function automatic lab_pkg::decode_out_t ref_dec(input row_t r);
        lab_pkg::decode_out_t d;
        d = '0;
        d.mux_y = 2'(r.a >> (int'(r.s) * 2));
        d.dec_y = r.en ? 8'(1 << int'(r.x)) : 8'h00;
        if (r.ec_en) begin
            for (int i = 7; i >= 0; i--) begin
                if (r.ec_x[i] && !d.enc_valid) begin
                    d.enc_y = 3'(i);   // first hit from the top
                    d.enc_valid = 1'b1;
                end
            end
        end
        return d;
    endfunction

    task automatic add_row(input logic [7:0] ra, input logic [1:0] rs, input logic [2:0] rx,
                           input logic ren, input logic [7:0] rec, input logic rece,
                           input lab_pkg::alu_op_e op, input logic [3:0] aa,
                           input logic [3:0] bb, input logic cin, input logic [3:0] es,
                           input logic [2:0] cvz);
        row_t r;
        r = '{ra, rs, rx, ren, rec, rece, op, aa, bb, cin, 8'h00, es, cvz};
        r.sw = {6'(rand_bits(6)), 2'b00};   // keep led block idle
        rows.push_back(r);
    endtask

    task automatic drive_row(input row_t r);
        a = r.a;
        s = r.s;
        x = r.x;
        en = r.en;
        ec_x = r.ec_x;
        ec_en = r.ec_en;
        alu_a = r.aa;
        alu_b = r.bb;
        alu_c = r.cin;
        alu_op = r.op;
        sw = r.sw;
    endtask

    task automatic build_rows();
        row_t r;
        logic [31:0] v;
        logic [6:0] e;
        add_row(8'hA5, 2'd0, 3'd0, 1'b1, 8'h01, 1'b1, lab_pkg::op_add, 4'h3, 4'h4, 1'b0, 4'h7, 3'b000);
        add_row(8'hA5, 2'd1, 3'd1, 1'b1, 8'h80, 1'b1, lab_pkg::op_add, 4'h7, 4'h1, 1'b0, 4'h8, 3'b010);
        add_row(8'hA5, 2'd2, 3'd2, 1'b0, 8'h00, 1'b1, lab_pkg::op_add, 4'hF, 4'h1, 1'b0, 4'h0, 3'b101);
        add_row(8'hA5, 2'd3, 3'd3, 1'b1, 8'hFF, 1'b0, lab_pkg::op_add, 4'h8, 4'h8, 1'b0, 4'h0, 3'b111);
        add_row(8'h1B, 2'd0, 3'd4, 1'b1, 8'h3C, 1'b1, lab_pkg::op_add, 4'h5, 4'hA, 1'b1, 4'h0, 3'b101);
        add_row(8'h1B, 2'd1, 3'd5, 1'b1, 8'h12, 1'b1, lab_pkg::op_add, 4'h2, 4'h3, 1'b1, 4'h6, 3'b000);
        add_row(8'h1B, 2'd2, 3'd6, 1'b0, 8'h40, 1'b1, lab_pkg::op_sub, 4'h5, 4'h3, 1'b0, 4'h2, 3'b000);
        add_row(8'h1B, 2'd3, 3'd7, 1'b1, 8'h04, 1'b1, lab_pkg::op_sub, 4'h3, 4'h5, 1'b0, 4'hE, 3'b100);
        add_row(8'hE4, 2'd0, 3'd7, 1'b1, 8'h02, 1'b0, lab_pkg::op_sub, 4'h8, 4'h1, 1'b0, 4'h7, 3'b010);
        add_row(8'hE4, 2'd1, 3'd0, 1'b0, 8'h21, 1'b1, lab_pkg::op_sub, 4'h7, 4'hF, 1'b0, 4'h8, 3'b110);
        add_row(8'hE4, 2'd2, 3'd3, 1'b1, 8'h08, 1'b1, lab_pkg::op_sub, 4'h4, 4'h4, 1'b0, 4'h0, 3'b001);
        add_row(8'hE4, 2'd3, 3'd6, 1'b1, 8'h10, 1'b1, lab_pkg::op_sub, 4'h4, 4'h3, 1'b1, 4'h0, 3'b001);
        add_row(8'h6C, 2'd0, 3'd2, 1'b1, 8'h00, 1'b0, lab_pkg::op_sub, 4'h0, 4'h0, 1'b1, 4'hF, 3'b100);
        add_row(8'h6C, 2'd1, 3'd5, 1'b1, 8'hC3, 1'b1, lab_pkg::op_and, 4'hC, 4'hA, 1'b1, 4'h8, 3'b000);
        add_row(8'h6C, 2'd2, 3'd1, 1'b0, 8'h05, 1'b1, lab_pkg::op_and, 4'h5, 4'hA, 1'b0, 4'h0, 3'b001);
        add_row(8'h6C, 2'd3, 3'd4, 1'b1, 8'h60, 1'b1, lab_pkg::op_or, 4'h5, 4'hA, 1'b1, 4'hF, 3'b000);
        add_row(8'h93, 2'd0, 3'd6, 1'b1, 8'h11, 1'b1, lab_pkg::op_or, 4'h0, 4'h0, 1'b0, 4'h0, 3'b001);
        add_row(8'h93, 2'd1, 3'd3, 1'b1, 8'h0A, 1'b1, lab_pkg::op_xor, 4'hC, 4'hA, 1'b0, 4'h6, 3'b000);
        add_row(8'h93, 2'd2, 3'd0, 1'b1, 8'h88, 1'b0, lab_pkg::op_xor, 4'h9, 4'h9, 1'b1, 4'h0, 3'b001);
        add_row(8'h93, 2'd3, 3'd7, 1'b0, 8'h7F, 1'b1, lab_pkg::op_not_a, 4'h5, 4'h0, 1'b0, 4'hA, 3'b000);
        add_row(8'h58, 2'd0, 3'd1, 1'b1, 8'h20, 1'b1, lab_pkg::op_not_a, 4'hF, 4'h3, 1'b1, 4'h0, 3'b001);
        add_row(8'h58, 2'd1, 3'd2, 1'b1, 8'h06, 1'b1, lab_pkg::op_lt, 4'h3, 4'h9, 1'b0, 4'h1, 3'b000);
        add_row(8'h58, 2'd2, 3'd4, 1'b1, 8'h00, 1'b1, lab_pkg::op_lt, 4'h9, 4'h3, 1'b1, 4'h0, 3'b001);
        add_row(8'h58, 2'd3, 3'd5, 1'b1, 8'hA0, 1'b1, lab_pkg::op_eq, 4'h6, 4'h6, 1'b0, 4'h1, 3'b000);
        add_row(8'hC7, 2'd1, 3'd6, 1'b1, 8'h03, 1'b1, lab_pkg::op_eq, 4'h6, 4'h7, 1'b0, 4'h0, 3'b001);
        for (int i = 0; i < N_RAND; i++) begin
            v = rand_bits(32);
            r.a = v[7:0];
            r.s = v[9:8];
            r.x = v[12:10];
            r.en = v[13];
            r.ec_x = v[21:14];
            r.ec_en = v[22];
            r.op = lab_pkg::alu_op_e'(v[25:23]);
            r.cin = v[26];
            v = rand_bits(14);
            r.aa = v[3:0];
            r.bb = v[7:4];
            r.sw = {v[13:8], 2'b00};
            e = ref_alu(r.aa, r.bb, r.cin, r.op);
            r.es = e[6:3];
            r.cvz = e[2:0];
            rows.push_back(r);
        end
    endtask

    task automatic run_rows();
        row_t r;
        lab_pkg::decode_out_t d;
        int n;
        n = rows.size();
        for (int k = 0; k < n + 2; k++) begin
            if (k < n) begin
                drive_row(rows[k]);
            end
            @(posedge clk);
            #1;
            check("ledr", 32'(ledr), 32'h0001);
            if (k < n) begin
                r = rows[k];
                d = ref_dec(r);
                check("y", 32'(y), 32'(d.mux_y));
                check("y_dec", 32'(y_dec), 32'(d.dec_y));
                check("ec_y", 32'(ec_y), 32'(d.enc_y));
                check("ec_valid", 32'(ec_valid), 32'(d.enc_valid));
                check("seg6", 32'(seg6), 32'(seg_of(r.sw[3:0])));
                check("seg7", 32'(seg7), 32'(seg_of(r.sw[7:4])));
            end
            if (k >= 1 && k - 1 < n) begin
                r = rows[k-1];
                d = ref_dec(r);
                check("alu_s", 32'(alu_s), 32'(r.es));
                check("alu_c_out", 32'(alu_c_out), 32'(r.cvz[2]));
                check("alu_ovf", 32'(alu_ovf), 32'(r.cvz[1]));
                check("alu_zero", 32'(alu_zero), 32'(r.cvz[0]));
                check("seg4", 32'(seg4),
                      d.enc_valid ? 32'(seg_of({1'b0, d.enc_y})) : 32'(`LAB_SEG_BLANK));
                check("seg5", 32'(seg5), 32'(seg_of({2'b00, d.mux_y})));
            end
            if (k >= 2) begin
                r = rows[k-2];
                check("seg0", 32'(seg0), 32'(seg_of(r.es)));
                check("seg1", 32'(seg1), 32'(seg_of({1'b0, r.cvz[0], r.cvz[1], r.cvz[2]})));
                check("seg2", 32'(seg2), 32'(seg_of(r.aa)));
                check("seg3", 32'(seg3), 32'(seg_of(r.bb)));
            end
        end
    endtask

    // waits for each led step and checks the rotation and its spacing
    task automatic led_steps(input int steps, input logic right);
        logic [15:0] prev, exp;
        int cyc;
        for (int i = 0; i < steps; i++) begin
            prev = ledr;
            exp = right ? {prev[0], prev[15:1]} : {prev[14:0], prev[15]};
            cyc = 0;
            while (ledr == prev) begin
                @(posedge clk);
                #1;
                cyc++;
                if (cyc > 2 * `LAB_LED_STEP + 4) begin
                    fail_run("ledr did not move although the running light is enabled");
                end
            end
            check("ledr", 32'(ledr), 32'(exp));
            if (i > 0) begin
                check("led_step_cycles", 32'(cyc), 32'(`LAB_LED_STEP));
            end
        end
    endtask

    initial begin
        #(WATCH_CYC * 10);
        $display("watchdog expired before the test finished");
        $display("*** TEST FAILED ***");
        $fatal(1);
    end

    initial begin
        logic [15:0] held;
        rst_n = 1'b0;
        drive_row('0);
        alu_op = lab_pkg::op_add;
        build_rows();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check("ledr", 32'(ledr), 32'h0001);
        check("y", 32'(y), 32'h0);
        check("y_dec", 32'(y_dec), 32'h0);
        check("ec_y", 32'(ec_y), 32'h0);
        check("ec_valid", 32'(ec_valid), 32'h0);
        check("alu_s", 32'(alu_s), 32'h0);
        check("alu_flags", 32'({alu_c_out, alu_ovf, alu_zero}), 32'h0);
        check("seg_all", {seg0, seg1, seg2, seg3}, {4{`LAB_SEG_BLANK}});
        check("seg_all_hi", {seg4, seg5, seg6, seg7}, {4{`LAB_SEG_BLANK}});

        run_rows();

        sw = 8'h01;   // run and rotate left
        led_steps(5, 1'b0);
        sw = 8'h03;
        led_steps(3, 1'b1);
        sw = 8'h00;
        held = ledr;
        repeat (3 * `LAB_LED_STEP) @(posedge clk);
        #1;
        check("ledr_hold", 32'(ledr), 32'(held));

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
